// File: access_sequencer.sv
`timescale 1ns/10ps
`default_nettype none

module access_sequencer (
    input  wire logic                               ACLK,
    input  wire logic                               ARESETn,
    // core fetch port
    input  wire logic                               fetch_req,
    input  wire logic [cpu_axi_pkg::AXI_ADDR_BITS-1:0] fetch_addr,
    output logic                                    fetch_done,
    // core data port
    input  wire cpu_axi_pkg::dm_req_t               dm_req,
    output logic                                    dm_done,
    // fetch read master
    output logic                                    im_start,
    output cpu_axi_pkg::ax_chan_t                   im_ax,
    input  wire logic                               im_done,
    // data read master
    output logic                                    dr_start,
    output cpu_axi_pkg::ax_chan_t                   dr_ax,
    input  wire logic                               dr_done,
    // data write master
    output logic                                    dw_start,
    output cpu_axi_pkg::ax_chan_t                   dw_ax,
    output cpu_axi_pkg::w_chan_t                    dw_w,
    input  wire logic                               dw_done
);
    import cpu_axi_pkg::*;

    // busy bit per master
    localparam int B_IM = 0;
    localparam int B_DR = 1;
    localparam int B_DW = 2;

    logic [2:0] busy;
    logic [2:0] done_vec;
    logic       seq_free;
    logic       dm_rd_pend;
    logic       dm_wr_pend;
    ax_chan_t   im_ax_q;
    ax_chan_t   dm_ax_q;
    w_chan_t    dw_w_q;

    // single word incr request, id filled by the master
    function automatic ax_chan_t word_ax(input logic [AXI_ADDR_BITS-1:0] addr);
        ax_chan_t ax;
        ax.id    = '0;
        ax.addr  = addr;
        ax.len   = '0;
        ax.size  = SIZE_WORD;
        ax.burst = BURST_INCR;
        return ax;
    endfunction

    assign dm_rd_pend = (dm_req.op == DM_READ);
    assign dm_wr_pend = (dm_req.op == DM_WRITE);
    assign seq_free   = (busy == 3'b000);
    assign done_vec   = {dw_done, dr_done, im_done};

    // start pulses and busy tracking
    always_ff @(posedge ACLK or negedge ARESETn) begin
        if (!ARESETn) begin
            busy     <= '0;
            im_start <= 1'b0;
            dr_start <= 1'b0;
            dw_start <= 1'b0;
        end else begin
            im_start <= 1'b0;
            dr_start <= 1'b0;
            dw_start <= 1'b0;
            busy     <= busy & ~done_vec;
            // data access wins over fetch
            if (seq_free) begin
                if (dm_rd_pend) begin
                    dr_start   <= 1'b1;
                    busy[B_DR] <= 1'b1;
                end else if (dm_wr_pend) begin
                    dw_start   <= 1'b1;
                    busy[B_DW] <= 1'b1;
                end else if (fetch_req) begin
                    im_start   <= 1'b1;
                    busy[B_IM] <= 1'b1;
                end
            end
        end
    end

    // request payloads, taken while nothing is in flight
    always_ff @(posedge ACLK) begin
        if (seq_free) begin
            im_ax_q     <= word_ax(fetch_addr);
            dm_ax_q     <= word_ax(dm_req.addr);
            dw_w_q.data <= dm_req.wdata;
            // core enables are active low
            dw_w_q.strb <= ~dm_req.bweb;
            dw_w_q.last <= 1'b1;
        end
    end

    assign im_ax = im_ax_q;
    assign dr_ax = dm_ax_q;
    assign dw_ax = dm_ax_q;
    assign dw_w  = dw_w_q;

    // done goes straight back to the core
    assign fetch_done = im_done;
    assign dm_done    = dr_done | dw_done;

    // a master only finishes what was started on it
    a_done_busy: assert property (@(posedge ACLK) disable iff (!ARESETn)
        (done_vec & ~busy) == 3'b000);

endmodule

`default_nettype wire

// File: axi_read_master.sv
`timescale 1ns/10ps
`default_nettype none

module axi_read_master #(
    parameter logic [cpu_axi_pkg::AXI_ID_BITS-1:0] ID = 1
) (
    input  wire logic                               ACLK,
    input  wire logic                               ARESETn,
    // one-cycle kick from the sequencer
    input  wire logic                               start,
    input  wire cpu_axi_pkg::ax_chan_t              req,
    // ar channel
    output logic                                    arvalid,
    output cpu_axi_pkg::ax_chan_t                   ar,
    input  wire logic                               arready,
    // r channel
    input  wire cpu_axi_pkg::r_chan_t               r,
    input  wire logic                               rvalid,
    output logic                                    rready,
    // finish pulse and read word
    output logic                                    done,
    output logic [cpu_axi_pkg::AXI_DATA_BITS-1:0]   rdata
);
    import cpu_axi_pkg::*;

    typedef enum logic [1:0] {
        RD_IDLE,
        RD_ADDR,
        RD_DWAIT,
        RD_DACC
    } rd_state_e;

    rd_state_e state;
    rd_state_e state_nxt;
    ax_chan_t  ar_q;

    // next state
    always_comb begin
        state_nxt = state;
        case (state)
            RD_IDLE: begin
                if (start)
                    state_nxt = RD_ADDR;
            end
            RD_ADDR: begin
                if (arvalid && arready)
                    state_nxt = RD_DWAIT;
            end
            // see rvalid first, raise rready a cycle later
            RD_DWAIT: begin
                if (rvalid)
                    state_nxt = RD_DACC;
            end
            RD_DACC: begin
                if (rvalid && rready)
                    state_nxt = RD_IDLE;
            end
            default: state_nxt = RD_IDLE;
        endcase
    end

    always_ff @(posedge ACLK or negedge ARESETn) begin
        if (!ARESETn)
            state <= RD_IDLE;
        else
            state <= state_nxt;
    end

    // address latched at start, single word beat
    always_ff @(posedge ACLK) begin
        if (start) begin
            ar_q.id    <= ID;
            ar_q.addr  <= req.addr;
            ar_q.len   <= '0;
            ar_q.size  <= SIZE_WORD;
            ar_q.burst <= BURST_INCR;
        end
    end

    assign ar      = ar_q;
    assign arvalid = (state == RD_ADDR);
    assign rready  = (state == RD_DACC);
    // finish on the r transfer itself
    assign done    = rvalid && rready;
    assign rdata   = r.data;

    // address held until taken
    a_ar_hold: assert property (@(posedge ACLK) disable iff (!ARESETn)
        arvalid && !arready |=> arvalid && $stable(ar));

    // never accept a beat that is not there
    a_rready_valid: assert property (@(posedge ACLK) disable iff (!ARESETn)
        rready |-> rvalid);

    // sequencer only kicks an idle master
    a_start_idle: assert property (@(posedge ACLK) disable iff (!ARESETn)
        start |-> state == RD_IDLE);

endmodule

`default_nettype wire

// File: axi_write_master.sv
`timescale 1ns/10ps
`default_nettype none

module axi_write_master #(
    parameter logic [cpu_axi_pkg::AXI_ID_BITS-1:0] ID = 2
) (
    input  wire logic                   ACLK,
    input  wire logic                   ARESETn,
    // one-cycle kick from the sequencer
    input  wire logic                   start,
    input  wire cpu_axi_pkg::ax_chan_t  req,
    input  wire cpu_axi_pkg::w_chan_t   wreq,
    // aw channel
    output cpu_axi_pkg::ax_chan_t       aw,
    output logic                        awvalid,
    input  wire logic                   awready,
    // w channel
    output cpu_axi_pkg::w_chan_t        w,
    output logic                        wvalid,
    input  wire logic                   wready,
    // b channel
    input  wire cpu_axi_pkg::b_chan_t   b,
    input  wire logic                   bvalid,
    output logic                        bready,
    // finish pulse
    output logic                        done
);
    import cpu_axi_pkg::*;

    typedef enum logic [2:0] {
        WR_IDLE,
        WR_ADDR,
        WR_DATA,
        WR_RWAIT,
        WR_RACC
    } wr_state_e;

    wr_state_e state;
    wr_state_e state_nxt;
    ax_chan_t  aw_q;
    w_chan_t   w_q;

    always_comb begin
        state_nxt = state;
        case (state)
            WR_IDLE: begin
                if (start)
                    state_nxt = WR_ADDR;
            end
            WR_ADDR: begin
                if (awvalid && awready)
                    state_nxt = WR_DATA;
            end
            // data only after the address went out
            WR_DATA: begin
                if (wvalid && wready)
                    state_nxt = WR_RWAIT;
            end
            WR_RWAIT: begin
                if (bvalid)
                    state_nxt = WR_RACC;
            end
            WR_RACC: begin
                if (bvalid && bready)
                    state_nxt = WR_IDLE;
            end
            default: state_nxt = WR_IDLE;
        endcase
    end

    always_ff @(posedge ACLK or negedge ARESETn) begin
        if (!ARESETn)
            state <= WR_IDLE;
        else
            state <= state_nxt;
    end

    // address and data captured at start
    always_ff @(posedge ACLK) begin
        if (start) begin
            aw_q.id    <= ID;
            aw_q.addr  <= req.addr;
            aw_q.len   <= '0;
            aw_q.size  <= SIZE_WORD;
            aw_q.burst <= BURST_INCR;
            w_q.data   <= wreq.data;
            w_q.strb   <= wreq.strb;
            // single beat, always the last one
            w_q.last   <= 1'b1;
        end
    end

    assign aw      = aw_q;
    assign w       = w_q;
    assign awvalid = (state == WR_ADDR);
    assign wvalid  = (state == WR_DATA);
    assign bready  = (state == WR_RACC);
    // finish on the b transfer
    assign done    = bvalid && bready;

    a_bready_valid: assert property (@(posedge ACLK) disable iff (!ARESETn)
        bready |-> bvalid);

    // slave answers with the id it was given
    a_bid: assert property (@(posedge ACLK) disable iff (!ARESETn)
        bvalid && bready |-> b.id == aw_q.id);

endmodule

`default_nettype wire

// File: cpu_axi_bridge.sv
`timescale 1ns/10ps
`default_nettype none

module cpu_axi_bridge #(
    parameter logic [cpu_axi_pkg::AXI_ID_BITS-1:0] IM_ID = 1,
    parameter logic [cpu_axi_pkg::AXI_ID_BITS-1:0] DM_ID = 2
) (
    input  wire logic                                   ACLK,
    input  wire logic                                   ARESETn,
    // core fetch port
    input  wire logic                                   fetch_req,
    input  wire logic [cpu_axi_pkg::AXI_ADDR_BITS-1:0]  fetch_addr,
    output logic                                        fetch_done,
    output logic [cpu_axi_pkg::AXI_DATA_BITS-1:0]       fetch_inst,
    // core data port
    input  wire cpu_axi_pkg::dm_req_t                   dm_req,
    output logic                                        dm_done,
    output logic [cpu_axi_pkg::AXI_DATA_BITS-1:0]       dm_rdata,
    // m0 ar / r
    output cpu_axi_pkg::ax_chan_t                       m0_ar,
    output logic                                        m0_arvalid,
    input  wire logic                                   m0_arready,
    input  wire cpu_axi_pkg::r_chan_t                   m0_r,
    input  wire logic                                   m0_rvalid,
    output logic                                        m0_rready,
    // m1 ar / r
    output cpu_axi_pkg::ax_chan_t                       m1_ar,
    output logic                                        m1_arvalid,
    input  wire logic                                   m1_arready,
    input  wire cpu_axi_pkg::r_chan_t                   m1_r,
    input  wire logic                                   m1_rvalid,
    output logic                                        m1_rready,
    // m1 aw / w / b
    output cpu_axi_pkg::ax_chan_t                       m1_aw,
    output logic                                        m1_awvalid,
    input  wire logic                                   m1_awready,
    output cpu_axi_pkg::w_chan_t                        m1_w,
    output logic                                        m1_wvalid,
    input  wire logic                                   m1_wready,
    input  wire cpu_axi_pkg::b_chan_t                   m1_b,
    input  wire logic                                   m1_bvalid,
    output logic                                        m1_bready
);
    import cpu_axi_pkg::*;

    // sequencer to master handshakes
    logic     im_start;
    logic     im_done;
    ax_chan_t im_ax;
    logic     dr_start;
    logic     dr_done;
    ax_chan_t dr_ax;
    logic     dw_start;
    logic     dw_done;
    ax_chan_t dw_ax;
    w_chan_t  dw_w;

    access_sequencer u_seq (
        .ACLK       (ACLK),
        .ARESETn    (ARESETn),
        .fetch_req  (fetch_req),
        .fetch_addr (fetch_addr),
        .fetch_done (fetch_done),
        .dm_req     (dm_req),
        .dm_done    (dm_done),
        .im_start   (im_start),
        .im_ax      (im_ax),
        .im_done    (im_done),
        .dr_start   (dr_start),
        .dr_ax      (dr_ax),
        .dr_done    (dr_done),
        .dw_start   (dw_start),
        .dw_ax      (dw_ax),
        .dw_w       (dw_w),
        .dw_done    (dw_done)
    );

    // master 0, instruction fetch
    axi_read_master #(.ID(IM_ID)) u_im_read (
        .ACLK    (ACLK),
        .ARESETn (ARESETn),
        .start   (im_start),
        .req     (im_ax),
        .arvalid (m0_arvalid),
        .ar      (m0_ar),
        .arready (m0_arready),
        .r       (m0_r),
        .rvalid  (m0_rvalid),
        .rready  (m0_rready),
        .done    (im_done),
        .rdata   (fetch_inst)
    );

    // master 1 read side
    axi_read_master #(.ID(DM_ID)) u_dm_read (
        .ACLK    (ACLK),
        .ARESETn (ARESETn),
        .start   (dr_start),
        .req     (dr_ax),
        .arvalid (m1_arvalid),
        .ar      (m1_ar),
        .arready (m1_arready),
        .r       (m1_r),
        .rvalid  (m1_rvalid),
        .rready  (m1_rready),
        .done    (dr_done),
        .rdata   (dm_rdata)
    );

    // master 1 write side
    axi_write_master #(.ID(DM_ID)) u_dm_write (
        .ACLK    (ACLK),
        .ARESETn (ARESETn),
        .start   (dw_start),
        .req     (dw_ax),
        .wreq    (dw_w),
        .aw      (m1_aw),
        .awvalid (m1_awvalid),
        .awready (m1_awready),
        .w       (m1_w),
        .wvalid  (m1_wvalid),
        .wready  (m1_wready),
        .b       (m1_b),
        .bvalid  (m1_bvalid),
        .bready  (m1_bready),
        .done    (dw_done)
    );

endmodule

`default_nettype wire

// File: cpu_axi_pkg.sv
`default_nettype none

package cpu_axi_pkg;

    // axi field widths
    localparam int AXI_ID_BITS   = 4;
    localparam int AXI_ADDR_BITS = 32;
    localparam int AXI_DATA_BITS = 32;
    localparam int AXI_STRB_BITS = 4;
    localparam int AXI_LEN_BITS  = 4;
    localparam int AXI_SIZE_BITS = 3;

    // 4 bytes per beat
    localparam logic [AXI_SIZE_BITS-1:0] SIZE_WORD = 3'b010;
    // incrementing burst
    localparam logic [1:0] BURST_INCR = 2'b01;

    // address channel, shared by ar and aw
    typedef struct packed {
        logic [AXI_ID_BITS-1:0]   id;
        logic [AXI_ADDR_BITS-1:0] addr;
        logic [AXI_LEN_BITS-1:0]  len;
        logic [AXI_SIZE_BITS-1:0] size;
        logic [1:0]               burst;
    } ax_chan_t;

    // write data beat
    typedef struct packed {
        logic [AXI_DATA_BITS-1:0] data;
        logic [AXI_STRB_BITS-1:0] strb;
        logic                     last;
    } w_chan_t;

    // read data beat
    typedef struct packed {
        logic [AXI_ID_BITS-1:0]   id;
        logic [AXI_DATA_BITS-1:0] data;
        logic [1:0]               resp;
        logic                     last;
    } r_chan_t;

    // write response
    typedef struct packed {
        logic [AXI_ID_BITS-1:0] id;
        logic [1:0]             resp;
    } b_chan_t;

    // core data op, same coding as the core drives it
    typedef enum logic [1:0] {
        DM_IDLE  = 2'd0,
        DM_WRITE = 2'd1,
        DM_READ  = 2'd2
    } dm_op_e;

    // held by the core until dm_done
    typedef struct packed {
        dm_op_e                   op;
        logic [AXI_ADDR_BITS-1:0] addr;
        logic [AXI_DATA_BITS-1:0] wdata;
        // byte enables, active low
        logic [AXI_STRB_BITS-1:0] bweb;
    } dm_req_t;

endpackage

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# build and run the bridge testbench with verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module tb_cpu_axi_bridge -f vlog.f || exit 1
out=$(./obj_dir/Vtb_cpu_axi_bridge 2>&1)
echo "$out"
echo "$out" | grep -qx "sim passed" && exit 0 || exit 1

// File: tb_axi_mem.sv
`timescale 1ns/10ps
`default_nettype none

module tb_axi_mem (
    input  wire logic                   ACLK,
    input  wire cpu_axi_pkg::ax_chan_t  m0_ar,
    input  wire logic                   m0_arvalid,
    output logic                        m0_arready,
    output cpu_axi_pkg::r_chan_t        m0_r,
    output logic                        m0_rvalid,
    input  wire logic                   m0_rready,
    input  wire cpu_axi_pkg::ax_chan_t  m1_ar,
    input  wire logic                   m1_arvalid,
    output logic                        m1_arready,
    output cpu_axi_pkg::r_chan_t        m1_r,
    output logic                        m1_rvalid,
    input  wire logic                   m1_rready,
    input  wire cpu_axi_pkg::ax_chan_t  m1_aw,
    input  wire logic                   m1_awvalid,
    output logic                        m1_awready,
    input  wire cpu_axi_pkg::w_chan_t   m1_w,
    input  wire logic                   m1_wvalid,
    output logic                        m1_wready,
    output cpu_axi_pkg::b_chan_t        m1_b,
    output logic                        m1_bvalid,
    input  wire logic                   m1_bready
);
    import cpu_axi_pkg::*;

    // 64 words, indexed by addr[7:2]
    logic [31:0] mem [64];
    logic [15:0] lfsr_state = 16'd39947;
    ax_chan_t    ar0_q;
    ax_chan_t    ar1_q;
    ax_chan_t    aw_q;
    w_chan_t     w_q;

    // x^16 + x^14 + x^13 + x^11, one step per bit
    function automatic int rand_delay();
        int   v;
        logic fb;
        v = 0;
        for (int i = 0; i < 2; i++) begin
            fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
            lfsr_state = {lfsr_state[14:0], fb};
            v = v * 2 + int'(fb);
        end
        return v;
    endfunction

    // n idle cycles, then drive just after the edge
    task automatic wait_cycles(input int n);
        repeat (n + 1) @(posedge ACLK);
        #1;
    endtask

    initial begin
        for (int i = 0; i < 64; i++)
            mem[i] = 32'hA500_0000 ^ (i * 32'h0101_0107);
    end

    // m0 read port
    initial begin
        m0_arready = 1'b0;
        m0_rvalid  = 1'b0;
        m0_r       = '0;
        forever begin
            @(negedge ACLK);
            if (m0_arvalid) begin
                wait_cycles(rand_delay());
                m0_arready = 1'b1;
                ar0_q      = m0_ar;
                @(posedge ACLK);
                #1 m0_arready = 1'b0;
                wait_cycles(rand_delay());
                m0_r.id   = ar0_q.id;
                m0_r.data = mem[ar0_q.addr[7:2]];
                m0_r.resp = 2'b00;
                m0_r.last = 1'b1;
                m0_rvalid = 1'b1;
                do @(negedge ACLK); while (!m0_rready);
                @(posedge ACLK);
                #1 m0_rvalid = 1'b0;
            end
        end
    end

    // m1 read port
    initial begin
        m1_arready = 1'b0;
        m1_rvalid  = 1'b0;
        m1_r       = '0;
        forever begin
            @(negedge ACLK);
            if (m1_arvalid) begin
                wait_cycles(rand_delay());
                m1_arready = 1'b1;
                ar1_q      = m1_ar;
                @(posedge ACLK);
                #1 m1_arready = 1'b0;
                wait_cycles(rand_delay());
                m1_r.id   = ar1_q.id;
                m1_r.data = mem[ar1_q.addr[7:2]];
                m1_r.resp = 2'b00;
                m1_r.last = 1'b1;
                m1_rvalid = 1'b1;
                do @(negedge ACLK); while (!m1_rready);
                @(posedge ACLK);
                #1 m1_rvalid = 1'b0;
            end
        end
    end

    // m1 write port, aw then w then b
    initial begin
        m1_awready = 1'b0;
        m1_wready  = 1'b0;
        m1_bvalid  = 1'b0;
        m1_b       = '0;
        forever begin
            @(negedge ACLK);
            if (m1_awvalid) begin
                wait_cycles(rand_delay());
                m1_awready = 1'b1;
                aw_q       = m1_aw;
                @(posedge ACLK);
                #1 m1_awready = 1'b0;
                do @(negedge ACLK); while (!m1_wvalid);
                wait_cycles(rand_delay());
                m1_wready = 1'b1;
                w_q       = m1_w;
                @(posedge ACLK);
                #1 m1_wready = 1'b0;
                for (int i = 0; i < 4; i++) begin
                    if (w_q.strb[i])
                        mem[aw_q.addr[7:2]][8*i +: 8] = w_q.data[8*i +: 8];
                end
                wait_cycles(rand_delay());
                m1_b.id   = aw_q.id;
                m1_b.resp = 2'b00;
                m1_bvalid = 1'b1;
                do @(negedge ACLK); while (!m1_bready);
                @(posedge ACLK);
                #1 m1_bvalid = 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// File: tb_cpu_axi_bridge.sv
`timescale 1ns/10ps
`default_nettype none

module tb_cpu_axi_bridge;
    import cpu_axi_pkg::*;

    localparam logic [AXI_ID_BITS-1:0] IM_ID = 4'd1;
    localparam logic [AXI_ID_BITS-1:0] DM_ID = 4'd2;
    localparam int NUM_TESTS = 120;
    // up to two requests per test
    localparam int WATCHDOG_CYCLES = NUM_TESTS * 2 * 40 + 20;

    logic        ACLK;
    logic        ARESETn;
    logic        fetch_req;
    logic [31:0] fetch_addr;
    logic        fetch_done;
    logic [31:0] fetch_inst;
    dm_req_t     dm_req;
    logic        dm_done;
    logic [31:0] dm_rdata;
    ax_chan_t    m0_ar;
    logic        m0_arvalid;
    logic        m0_arready;
    r_chan_t     m0_r;
    logic        m0_rvalid;
    logic        m0_rready;
    ax_chan_t    m1_ar;
    logic        m1_arvalid;
    logic        m1_arready;
    r_chan_t     m1_r;
    logic        m1_rvalid;
    logic        m1_rready;
    ax_chan_t    m1_aw;
    logic        m1_awvalid;
    logic        m1_awready;
    w_chan_t     m1_w;
    logic        m1_wvalid;
    logic        m1_wready;
    b_chan_t     m1_b;
    logic        m1_bvalid;
    logic        m1_bready;

    logic [31:0] shadow [64];
    logic [15:0] lfsr_state = 16'd39947;
    int          errors = 0;
    int          failed_tests = 0;
    // which master put out an address first, -1 for none yet
    int          first_addr = -1;

    // monitor history from the previous negedge
    logic        rst_done_q = 1'b0;
    logic        m0_act = 1'b0;
    logic        m1_act = 1'b0;
    logic        ar0_wait = 1'b0;
    logic        ar1_wait = 1'b0;
    logic        aw_wait = 1'b0;
    logic        w_wait = 1'b0;
    ax_chan_t    ar0_prev;
    ax_chan_t    ar1_prev;
    ax_chan_t    aw_prev;
    w_chan_t     w_prev;
    logic [5:0]  hs_prev = '0;

    cpu_axi_bridge #(.IM_ID(IM_ID), .DM_ID(DM_ID)) u_cpu_axi_bridge (.*);

    tb_axi_mem u_mem (.*);

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        logic        fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
            lfsr_state = {lfsr_state[14:0], fb};
            v = {v[30:0], fb};
        end
        return v;
    endfunction

    task automatic report_value(input string name, input logic [63:0] exp,
                                input logic [63:0] got);
        $display("Error at %0t: %s expected %h got %h", $time, name, exp, got);
        errors++;
    endtask

    task automatic report_text(input string what);
        $display("Error at %0t: %s", $time, what);
        errors++;
    endtask

    // ready must come exactly one cycle after valid is first seen
    task automatic check_ready(input string name, input logic valid_prev,
                               input logic ready_prev, input logic ready_now);
        if (ready_now && !valid_prev)
            report_text({name, " rose before valid was seen"});
        if (valid_prev && !ready_prev && !ready_now)
            report_text({name, " did not rise one cycle after valid"});
    endtask

    // one single-word incr request on an address channel
    task automatic check_ax(input string name, input ax_chan_t ax,
                            input logic [AXI_ID_BITS-1:0] id_exp,
                            input logic [31:0] addr_exp);
        if (ax.id !== id_exp)
            report_value({name, ".id"}, 64'(id_exp), 64'(ax.id));
        if (ax.addr !== addr_exp)
            report_value({name, ".addr"}, 64'(addr_exp), 64'(ax.addr));
        if (ax.len !== 4'd0)
            report_value({name, ".len"}, 64'd0, 64'(ax.len));
        // 4 bytes per beat
        if (ax.size !== 3'b010)
            report_value({name, ".size"}, 64'd2, 64'(ax.size));
        // incrementing burst
        if (ax.burst !== 2'b01)
            report_value({name, ".burst"}, 64'd1, 64'(ax.burst));
    endtask

    initial begin
        ACLK = 1'b0;
        forever #4 ACLK = ~ACLK;
    end

    always @(negedge ACLK) begin
        logic [3:0] strb_exp;
        if (!ARESETn || !rst_done_q) begin
            if ({fetch_done, dm_done, m0_arvalid, m0_rready, m1_arvalid, m1_rready,
                 m1_awvalid, m1_wvalid, m1_bready} != 9'd0)
                report_text("valid, ready or done output high around reset");
        end
        rst_done_q = ARESETn;
        if (ARESETn) begin
            if (first_addr < 0 && (m1_arvalid || m1_awvalid))
                first_addr = 1;
            else if (first_addr < 0 && m0_arvalid)
                first_addr = 0;
            // address fields against the held core requests
            if (m0_arvalid)
                check_ax("m0_ar", m0_ar, IM_ID, fetch_addr);
            if (m1_arvalid)
                check_ax("m1_ar", m1_ar, DM_ID, dm_req.addr);
            if (m1_awvalid)
                check_ax("m1_aw", m1_aw, DM_ID, dm_req.addr);
            // write beat against the held core request
            strb_exp = ~dm_req.bweb;
            if (m1_wvalid && m1_w.strb !== strb_exp)
                report_value("m1_w.strb", 64'(strb_exp), 64'(m1_w.strb));
            if (m1_wvalid && m1_w.data !== dm_req.wdata)
                report_value("m1_w.data", 64'(dm_req.wdata), 64'(m1_w.data));
            if (m1_wvalid && m1_w.last !== 1'b1)
                report_value("m1_w.last", 64'd1, 64'(m1_w.last));
            // hold until taken
            if (ar0_wait && (!m0_arvalid || m0_ar !== ar0_prev))
                report_text("m0 ar channel changed before arready");
            if (ar1_wait && (!m1_arvalid || m1_ar !== ar1_prev))
                report_text("m1 ar channel changed before arready");
            if (aw_wait && (!m1_awvalid || m1_aw !== aw_prev))
                report_text("m1 aw channel changed before awready");
            if (w_wait && (!m1_wvalid || m1_w !== w_prev))
                report_text("m1 w channel changed before wready");
            check_ready("m0_rready", hs_prev[0], hs_prev[1], m0_rready);
            check_ready("m1_rready", hs_prev[2], hs_prev[3], m1_rready);
            check_ready("m1_bready", hs_prev[4], hs_prev[5], m1_bready);
            // masters never in flight together
            if ((m0_act || m0_arvalid) && (m1_act || m1_arvalid || m1_awvalid))
                report_text("m0 and m1 both in flight");
            m0_act = (m0_act || m0_arvalid) && !(m0_rvalid && m0_rready);
            m1_act = (m1_act || m1_arvalid || m1_awvalid)
                     && !(m1_rvalid && m1_rready) && !(m1_bvalid && m1_bready);
        end
        ar0_wait = m0_arvalid && !m0_arready;
        ar1_wait = m1_arvalid && !m1_arready;
        aw_wait  = m1_awvalid && !m1_awready;
        w_wait   = m1_wvalid && !m1_wready;
        ar0_prev = m0_ar;
        ar1_prev = m1_ar;
        aw_prev  = m1_aw;
        w_prev   = m1_w;
        hs_prev  = {m1_bready, m1_bvalid, m1_rready, m1_rvalid, m0_rready, m0_rvalid};
    end

    // one fetch and/or one data request, held until each done
    task automatic run_access(input logic do_fetch, input logic do_dm, input dm_op_e op,
                              input logic [31:0] f_addr, input logic [31:0] d_addr,
                              input logic [31:0] wdata, input logic [3:0] bweb);
        logic        f_pend;
        logic        d_pend;
        logic        f_seen;
        logic        d_seen;
        logic [31:0] exp;
        @(posedge ACLK);
        #1;
        first_addr   = -1;
        fetch_req    = do_fetch;
        fetch_addr   = f_addr;
        dm_req.op    = do_dm ? op : DM_IDLE;
        dm_req.addr  = d_addr;
        dm_req.wdata = wdata;
        dm_req.bweb  = bweb;
        f_pend = do_fetch;
        d_pend = do_dm;
        while (f_pend || d_pend) begin
            @(negedge ACLK);
            f_seen = fetch_done;
            d_seen = dm_done;
            if (f_seen && !f_pend)
                report_text("fetch_done without a pending fetch");
            if (d_seen && !d_pend)
                report_text("dm_done without a pending data request");
            if (f_seen && f_pend) begin
                exp = shadow[f_addr[7:2]];
                if (fetch_inst !== exp)
                    report_value("fetch_inst", 64'(exp), 64'(fetch_inst));
            end
            if (d_seen && d_pend && op == DM_READ) begin
                exp = shadow[d_addr[7:2]];
                if (dm_rdata !== exp)
                    report_value("dm_rdata", 64'(exp), 64'(dm_rdata));
            end
            // active-low enables select the bytes written
            if (d_seen && d_pend && op == DM_WRITE) begin
                for (int i = 0; i < 4; i++) begin
                    if (!bweb[i])
                        shadow[d_addr[7:2]][8*i +: 8] = wdata[8*i +: 8];
                end
            end
            @(posedge ACLK);
            #1;
            if (f_seen) begin
                fetch_req = 1'b0;
                f_pend    = 1'b0;
            end
            if (d_seen) begin
                dm_req.op = DM_IDLE;
                d_pend    = 1'b0;
            end
        end
        if (do_fetch && do_dm && first_addr != 1)
            report_text("fetch address went out before the pending data access");
    endtask

    initial begin
        int          kind;
        int          err0;
        logic [31:0] fa;
        logic [31:0] da;
        logic [31:0] wd;
        logic [3:0]  be;
        dm_op_e      op;
        ARESETn    = 1'b0;
        fetch_req  = 1'b0;
        fetch_addr = '0;
        dm_req     = '0;
        for (int i = 0; i < 64; i++)
            shadow[i] = 32'hA500_0000 ^ (i * 32'h0101_0107);
        repeat (4) @(posedge ACLK);
        #1 ARESETn = 1'b1;
        for (int t = 0; t < NUM_TESTS; t++) begin
            err0 = errors;
            kind = int'(rand_bits(2));
            fa   = {24'd0, 6'(rand_bits(6)), 2'b00};
            da   = {24'd0, 6'(rand_bits(6)), 2'b00};
            wd   = rand_bits(32);
            be   = 4'(rand_bits(4));
            op   = (rand_bits(1) != 32'd0) ? DM_WRITE : DM_READ;
            case (kind)
                0: run_access(1'b1, 1'b0, DM_IDLE, fa, da, wd, be);
                1: run_access(1'b0, 1'b1, DM_READ, fa, da, wd, be);
                2: begin
                    // write, then read back the merged word
                    run_access(1'b0, 1'b1, DM_WRITE, fa, da, wd, be);
                    run_access(1'b0, 1'b1, DM_READ, fa, da, wd, be);
                end
                default: run_access(1'b1, 1'b1, op, fa, da, wd, be);
            endcase
            if (errors != err0)
                failed_tests++;
            $display("test %0d kind %0d addr %h: %s", t, kind, da,
                     (errors == err0) ? "ok" : "FAILED");
        end
        $display("%0d tests, %0d failed, %0d errors", NUM_TESTS, failed_tests, errors);
        if (errors == 0)
            $display("sim passed");
        else
            $display("sim failed");
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge ACLK);
        $display("timeout: a request never finished");
        $display("sim failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: vlog.f
cpu_axi_pkg.sv
axi_read_master.sv
axi_write_master.sv
access_sequencer.sv
cpu_axi_bridge.sv
tb_axi_mem.sv
tb_cpu_axi_bridge.sv
